/* source/mul_params.svh */
`ifndef MUL_PARAMS_SVH
`define MUL_PARAMS_SVH

// Operand width in bits
// A and B each hold one operand, X is one extra sign bit
`define MUL_WIDTH 8

// Add/shift pairs per product, one per multiplier bit
// The last pair subtracts to weight the sign bit negatively
`define MUL_STEPS `MUL_WIDTH

// Flops per button synchronizer, not counting the edge flop
`define MUL_SYNC_STAGES 2

`endif

/* source/mulPkg.sv */
`include "mul_params.svh"

package mulPkg;

    // One command word per cycle from the FSM to the datapath
    // Clear and load share a cycle on a load press
    // Add and subtract share the final add cycle
    typedef struct packed {
        // Zero A and X
        logic clearAX;
        // Copy sw into B
        logic loadB;
        // A and X take the adder result
        logic addStep;
        // Adder subtracts sw on the final step only
        logic subStep;
        // Arithmetic shift of {X, A, B} by one
        logic shiftStep;
    } mulCtrl_t;

    // Sequencer states
    typedef enum logic [2:0] {
        idle     = 3'd0,
        clearing = 3'd1,
        adding   = 3'd2,
        shifting = 3'd3,
        holding  = 3'd4
    } mulState_t;

    // Adder result with the new sign flag as MSB
    typedef struct packed {
        logic                   xNext;
        logic [`MUL_WIDTH-1:0]  aNext;
    } addSum_t;

endpackage

/* source/buttonSync.sv */
`timescale 1ns/1ps
`include "mul_params.svh"

module buttonSync (
    input  logic Clk,
    input  logic rst,
    input  logic clearALoadB,
    input  logic run,
    output logic loadPulse,
    output logic runPulse,
    output logic runLevel
);

    // Bit 0 is the load button, bit 1 is run
    logic [1:0] pressed;
    logic [`MUL_SYNC_STAGES-1:0][1:0] syncChain;
    logic [1:0] level;
    logic [1:0] prevLevel;

    // Buttons are active low, flip to a pressed level
    assign pressed = ~{run, clearALoadB};

    always_ff @(posedge Clk) begin
        if (rst) begin
            syncChain <= '0;
            prevLevel <= '0;
        end else begin
            // New sample enters at stage 0 and moves up one stage per cycle
            syncChain <= {syncChain[`MUL_SYNC_STAGES-2:0], pressed};
            prevLevel <= level;
        end
    end

    assign level = syncChain[`MUL_SYNC_STAGES-1];

    // Rising edge of the pressed level, i.e. falling edge of the pin
    assign loadPulse = level[0] & ~prevLevel[0];
    assign runPulse  = level[1] & ~prevLevel[1];

    // Held level lets the FSM wait for the run button to be released
    assign runLevel = level[1];

endmodule

/* source/mulControl.sv */
`timescale 1ns/1ps
`include "mul_params.svh"

module mulControl (
    input  logic             Clk,
    input  logic             rst,
    input  logic             loadPulse,
    input  logic             runPulse,
    input  logic             runLevel,
    output mulPkg::mulCtrl_t ctrl
);

    import mulPkg::*;

    localparam int CntW = (`MUL_STEPS > 1) ? $clog2(`MUL_STEPS) : 1;
    localparam logic [CntW-1:0] LastStep = CntW'(`MUL_STEPS - 1);

    mulState_t state;
    mulState_t stateNext;
    logic [CntW-1:0] stepCount;

    always_ff @(posedge Clk) begin
        if (rst) begin
            state     <= idle;
            stepCount <= '0;
        end else begin
            state <= stateNext;
            // Counter restarts on every new product
            if (state == clearing) begin
                stepCount <= '0;
            end else if (state == shifting) begin
                stepCount <= (stepCount == LastStep) ? '0 : stepCount + 1'b1;
            end
        end
    end

    always_comb begin
        stateNext = state;
        case (state)
            idle: begin
                if (runPulse) begin
                    stateNext = clearing;
                end
            end
            clearing: stateNext = adding;
            adding:   stateNext = shifting;
            shifting: begin
                // Result sits in {X, A, B} once the last pair is done
                if (stepCount == LastStep) begin
                    stateNext = holding;
                end else begin
                    stateNext = adding;
                end
            end
            holding: begin
                // Wait for release so a long press runs only once
                if (runPulse) begin
                    stateNext = clearing;
                end else if (!runLevel) begin
                    stateNext = idle;
                end
            end
            default: stateNext = idle;
        endcase
    end

    // Command decode from state
    // Load is the one input-driven term and must act in the pulse cycle
    always_comb begin
        ctrl = '0;
        case (state)
            idle, holding: begin
                ctrl.clearAX = loadPulse;
                ctrl.loadB   = loadPulse;
            end
            clearing: ctrl.clearAX = 1'b1;
            adding: begin
                ctrl.addStep = 1'b1;
                // Sign bit of B has negative weight
                ctrl.subStep = (stepCount == LastStep);
            end
            shifting: ctrl.shiftStep = 1'b1;
            default: ctrl = '0;
        endcase
    end

    // Datapath cannot add and shift in one cycle
    assert property (@(posedge Clk) disable iff (rst)
        !(ctrl.addStep && ctrl.shiftStep));

    assert property (@(posedge Clk) disable iff (rst)
        ctrl.subStep |-> ctrl.addStep);

    // A press during a product must not restart the step count
    assert property (@(posedge Clk) disable iff (rst)
        (runPulse && (state == adding || state == shifting)) |=>
            ((state != clearing) &&
             ((stepCount >= $past(stepCount)) || (state == holding))));

endmodule

/* source/addSub9.sv */
`timescale 1ns/1ps
`include "mul_params.svh"

module addSub9 (
    input  logic [`MUL_WIDTH-1:0] A,
    input  logic                  X,
    input  logic [`MUL_WIDTH-1:0] sw,
    input  logic                  mBit,
    input  logic                  subStep,
    output mulPkg::addSum_t       sum
);

    localparam int ExtW = `MUL_WIDTH + 1;

    logic [ExtW-1:0] aExt;
    logic [ExtW-1:0] swExt;
    logic [ExtW-1:0] operand;
    logic [ExtW-1:0] rippleSum;
    logic [ExtW-1:0] result;
    logic [ExtW-1:0] carry;

    // X always equals A's sign after a shift or a clear,
    // so {X, A} is the sign-extended A
    assign aExt  = {X, A};
    assign swExt = {sw[`MUL_WIDTH-1], sw};

    // Subtract as add of the inverted operand with carry in set
    assign operand  = swExt ^ {ExtW{subStep}};
    assign carry[0] = subStep;

    genvar i;
    generate
        for (i = 0; i < ExtW; i++) begin : gFullAdder
            assign rippleSum[i] = aExt[i] ^ operand[i] ^ carry[i];
            // Carry out of the top cell is dropped
            if (i < ExtW - 1) begin : gCarry
                assign carry[i+1] = (aExt[i] & operand[i]) |
                                    (carry[i] & (aExt[i] ^ operand[i]));
            end
        end
    endgenerate

    // Multiplier bit clear means A is kept as is
    assign result = mBit ? rippleSum : aExt;

    assign sum.xNext = result[ExtW-1];
    assign sum.aNext = result[`MUL_WIDTH-1:0];

endmodule

/* source/regUnit.sv */
`timescale 1ns/1ps
`include "mul_params.svh"

module regUnit (
    input  logic                  Clk,
    input  logic                  rst,
    input  mulPkg::mulCtrl_t      ctrl,
    input  logic [`MUL_WIDTH-1:0] sw,
    input  mulPkg::addSum_t       sum,
    output logic [`MUL_WIDTH-1:0] Aval,
    output logic [`MUL_WIDTH-1:0] Bval,
    output logic                  X
);

    always_ff @(posedge Clk) begin
        if (rst) begin
            X    <= 1'b0;
            Aval <= '0;
            Bval <= '0;
        end else if (ctrl.clearAX || ctrl.loadB) begin
            // Clear and load may come together on a load press
            if (ctrl.clearAX) begin
                X    <= 1'b0;
                Aval <= '0;
            end
            if (ctrl.loadB) begin
                Bval <= sw;
            end
        end else if (ctrl.addStep) begin
            // Adder already passes A through when B[0] is 0
            X    <= sum.xNext;
            Aval <= sum.aNext;
        end else if (ctrl.shiftStep) begin
            // X is kept, so the shift is arithmetic over {X, A, B}
            Aval <= {X, Aval[`MUL_WIDTH-1:1]};
            Bval <= {Aval[0], Bval[`MUL_WIDTH-1:1]};
        end
    end

    // Loading B mid-product would corrupt the multiplier bits
    assert property (@(posedge Clk) disable iff (rst)
        !(ctrl.loadB && ctrl.shiftStep));

endmodule

/* source/hexDriver.sv */
`timescale 1ns/1ps

module hexDriver (
    input  logic [3:0] nibble,
    output logic [6:0] segments
);

    // Bit order is {g, f, e, d, c, b, a}, a 0 lights the segment
    always_comb begin
        case (nibble)
            4'h0: segments = 7'b1000000;
            4'h1: segments = 7'b1111001;
            4'h2: segments = 7'b0100100;
            4'h3: segments = 7'b0110000;
            4'h4: segments = 7'b0011001;
            4'h5: segments = 7'b0010010;
            4'h6: segments = 7'b0000010;
            4'h7: segments = 7'b1111000;
            4'h8: segments = 7'b0000000;
            4'h9: segments = 7'b0010000;
            // Letters b and d are lower case so they differ from 8 and 0
            4'hA: segments = 7'b0001000;
            4'hB: segments = 7'b0000011;
            4'hC: segments = 7'b1000110;
            4'hD: segments = 7'b0100001;
            4'hE: segments = 7'b0000110;
            4'hF: segments = 7'b0001110;
            default: segments = 7'b1111111;
        endcase
    end

endmodule

/* source/multiplier.sv */
`timescale 1ns/1ps
`include "mul_params.svh"

module multiplier (
    input  logic                  Clk,
    input  logic                  rst,
    input  logic                  clearALoadB,
    input  logic                  run,
    input  logic [`MUL_WIDTH-1:0] sw,
    output logic [`MUL_WIDTH-1:0] Aval,
    output logic [`MUL_WIDTH-1:0] Bval,
    output logic                  X,
    output logic [6:0]            AhexU,
    output logic [6:0]            AhexL,
    output logic [6:0]            BhexU,
    output logic [6:0]            BhexL
);

    import mulPkg::*;

    logic     loadPulse;
    logic     runPulse;
    logic     runLevel;
    mulCtrl_t ctrl;
    addSum_t  sum;

    // Button edges to single-cycle pulses
    buttonSync buttonSync0 (
        .Clk         (Clk),
        .rst         (rst),
        .clearALoadB (clearALoadB),
        .run         (run),
        .loadPulse   (loadPulse),
        .runPulse    (runPulse),
        .runLevel    (runLevel)
    );

    mulControl mulControl0 (
        .Clk       (Clk),
        .rst       (rst),
        .loadPulse (loadPulse),
        .runPulse  (runPulse),
        .runLevel  (runLevel),
        .ctrl      (ctrl)
    );

    // B[0] is the current multiplier bit
    addSub9 addSub90 (
        .A       (Aval),
        .X       (X),
        .sw      (sw),
        .mBit    (Bval[0]),
        .subStep (ctrl.subStep),
        .sum     (sum)
    );

    regUnit regUnit0 (
        .Clk  (Clk),
        .rst  (rst),
        .ctrl (ctrl),
        .sw   (sw),
        .sum  (sum),
        .Aval (Aval),
        .Bval (Bval),
        .X    (X)
    );

    // Two digits per register show its low byte
    hexDriver hexAU (.nibble(Aval[7:4]), .segments(AhexU));
    hexDriver hexAL (.nibble(Aval[3:0]), .segments(AhexL));
    hexDriver hexBU (.nibble(Bval[7:4]), .segments(BhexU));
    hexDriver hexBL (.nibble(Bval[3:0]), .segments(BhexL));

endmodule

/* tests/multiplierTb.sv */
`timescale 1ns/1ps
`include "mul_params.svh"

module multiplierTb;

    localparam int W = `MUL_WIDTH;
    localparam int NumFixed = 12;
    localparam int NumRandom = 4;
    localparam int NumRows = NumFixed + NumRandom;
    // Result must be final this many edges after the press edge
    localparam int SettleLimit = 20;
    localparam int WaitCycles = 24;

    // One table row, B is loaded first unless the row chains
    typedef struct packed {
        logic [W-1:0] mcand;
        logic [W-1:0] bLoad;
        logic         chain;
        logic [7:0]   holdLen;
    } vector_t;

    logic         Clk;
    logic         rst;
    logic         clearALoadB;
    logic         run;
    logic [W-1:0] sw;
    logic [W-1:0] Aval;
    logic [W-1:0] Bval;
    logic         X;
    logic [6:0]   AhexU;
    logic [6:0]   AhexL;
    logic [6:0]   BhexU;
    logic [6:0]   BhexL;

    vector_t    vectors [NumRows];
    // Active-low segments {g, f, e, d, c, b, a} per hex digit
    logic [6:0] segRef [16];
    int         errors;
    int         seed;

    multiplier dut0 (
        .Clk         (Clk),
        .rst         (rst),
        .clearALoadB (clearALoadB),
        .run         (run),
        .sw          (sw),
        .Aval        (Aval),
        .Bval        (Bval),
        .X           (X),
        .AhexU       (AhexU),
        .AhexL       (AhexL),
        .BhexU       (BhexU),
        .BhexL       (BhexL)
    );

    always #5 Clk = ~Clk;

    function automatic vector_t makeVector(input logic [W-1:0] mcand, input logic [W-1:0] bLoad,
                                           input logic chain, input logic [7:0] holdLen);
        vector_t v;
        v.mcand   = mcand;
        v.bLoad   = bLoad;
        v.chain   = chain;
        v.holdLen = holdLen;
        return v;
    endfunction

    task automatic checkValue(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
        if (expected !== actual) begin
            $display("Fail %s expected %0h got %0h", name, expected, actual);
            errors++;
        end
    endtask

    // All four digits against the reference table
    task automatic checkDisplay(input logic [W-1:0] aExp, input logic [W-1:0] bExp);
        checkValue("AhexU", segRef[aExp[7:4]], AhexU);
        checkValue("AhexL", segRef[aExp[3:0]], AhexL);
        checkValue("BhexU", segRef[bExp[7:4]], BhexU);
        checkValue("BhexL", segRef[bExp[3:0]], BhexL);
    endtask

    // Press one button for holdLen cycles, then release
    // Tracks the last edge at which X, A or B moved
    task automatic pressButton(input logic isRun, input int holdLen, output int lastChange);
        logic [2*W:0] prevOut;
        logic [2*W:0] curOut;
        int           total;
        total = (holdLen > WaitCycles) ? holdLen + 4 : WaitCycles + 4;
        lastChange = -1;
        @(negedge Clk);
        prevOut = {X, Aval, Bval};
        @(posedge Clk);
        if (isRun) begin
            run <= 1'b0;
        end else begin
            clearALoadB <= 1'b0;
        end
        for (int i = 0; i < total; i++) begin
            @(posedge Clk);
            if (i + 1 == holdLen) begin
                run         <= 1'b1;
                clearALoadB <= 1'b1;
            end
            @(negedge Clk);
            curOut = {X, Aval, Bval};
            if (curOut !== prevOut) begin
                lastChange = i + 1;
            end
            prevOut = curOut;
        end
    endtask

    // A late change means the result was late or a second product ran
    task automatic checkSettled(input string what, input int lastChange);
        if (lastChange > SettleLimit) begin
            $display("Timeout: %s outputs still changing %0d cycles after the press",
                     what, lastChange);
            errors++;
        end
    endtask

    initial begin : main
        vector_t      v;
        logic [31:0]  randWord;
        logic [W-1:0] bVal;
        logic [W-1:0] prevB;
        logic [31:0]  prodBits;
        int           mcandInt;
        int           bInt;
        int           prodInt;
        int           lastChange;
        seed        = 29670;
        errors      = 0;
        Clk         = 1'b0;
        rst         = 1'b1;
        clearALoadB = 1'b1;
        run         = 1'b1;
        sw          = '0;

        segRef = '{7'b1000000, 7'b1111001, 7'b0100100, 7'b0110000,
                   7'b0011001, 7'b0010010, 7'b0000010, 7'b1111000,
                   7'b0000000, 7'b0010000, 7'b0001000, 7'b0000011,
                   7'b1000110, 7'b0100001, 7'b0000110, 7'b0001110};

        // Reference case first: C5 times 07 gives FE63
        vectors[0]  = makeVector(8'h07, 8'hC5, 1'b0, 8'd3);
        vectors[1]  = makeVector(8'h05, 8'h03, 1'b0, 8'd3);
        vectors[2]  = makeVector(8'hF6, 8'h0C, 1'b0, 8'd4);
        vectors[3]  = makeVector(8'h19, 8'hE7, 1'b0, 8'd3);
        vectors[4]  = makeVector(8'h9C, 8'h85, 1'b0, 8'd5);
        vectors[5]  = makeVector(8'h00, 8'h5A, 1'b0, 8'd3);
        vectors[6]  = makeVector(8'h80, 8'h80, 1'b0, 8'd3);
        vectors[7]  = makeVector(8'h80, 8'h7F, 1'b0, 8'd3);
        // Chained rows reuse the low byte of the last product
        vectors[8]  = makeVector(8'h03, 8'h00, 1'b1, 8'd3);
        vectors[9]  = makeVector(8'hFD, 8'h00, 1'b1, 8'd6);
        // Long press must still give one product
        vectors[10] = makeVector(8'h2B, 8'hD3, 1'b0, 8'd40);
        vectors[11] = makeVector(8'hFF, 8'h01, 1'b0, 8'd3);
        for (int i = NumFixed; i < NumRows; i++) begin
            randWord = $random(seed);
            vectors[i] = makeVector(randWord[W-1:0], randWord[2*W-1:W], 1'b0,
                                    8'd3 + {5'd0, randWord[18:16]});
        end

        for (int i = 0; i < 4; i++) begin
            @(posedge Clk);
        end
        rst <= 1'b0;
        @(negedge Clk);

        // Reset leaves 00 00 on the display
        checkValue("Aval", 0, Aval);
        checkValue("Bval", 0, Bval);
        checkValue("X", 0, X);
        checkDisplay('0, '0);
        prevB = '0;

        for (int r = 0; r < NumRows; r++) begin
            v = vectors[r];
            if (!v.chain) begin
                @(posedge Clk);
                sw <= v.bLoad;
                pressButton(1'b0, 3, lastChange);
                checkSettled("load", lastChange);
                checkValue("Bval", v.bLoad, Bval);
                checkValue("Aval", 0, Aval);
                checkValue("X", 0, X);
                bVal = v.bLoad;
            end else begin
                bVal = prevB;
            end

            @(posedge Clk);
            sw <= v.mcand;
            pressButton(1'b1, v.holdLen, lastChange);
            checkSettled("run", lastChange);

            // Signed product split into A, B and the sign flag
            mcandInt = $signed(v.mcand);
            bInt     = $signed(bVal);
            prodInt  = mcandInt * bInt;
            prodBits = prodInt;
            checkValue("Aval", prodBits[2*W-1:W], Aval);
            checkValue("Bval", prodBits[W-1:0], Bval);
            checkValue("X", (prodInt < 0) ? 1 : 0, X);
            checkDisplay(prodBits[2*W-1:W], prodBits[W-1:0]);
            prevB = prodBits[W-1:0];
        end

        $display("Rows run: %0d, errors: %0d", NumRows, errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

/* src.f */
+incdir+source
source/mulPkg.sv
source/buttonSync.sv
source/mulControl.sv
source/addSub9.sv
source/regUnit.sv
source/hexDriver.sv
source/multiplier.sv
tests/multiplierTb.sv

/* Bender.yml */
package:
  name: multiplier

sources:
  - include_dirs:
      - source
    files:
      - source/mulPkg.sv
      - source/buttonSync.sv
      - source/mulControl.sv
      - source/addSub9.sv
      - source/regUnit.sv
      - source/hexDriver.sv
      - source/multiplier.sv
  - target: test
    include_dirs:
      - source
    files:
      - tests/multiplierTb.sv
